//--- verilog/masku_pkg.sv
// Mask unit package
// Widths, constants and packed structs shared by the mask-logical datapath

`default_nettype none

package masku_pkg;

  //////////////////////////////
  // Constants
  //////////////////////////////

  // One lane word
  localparam int unsigned ElenBits = 64;
  // Instruction ids in flight at the sequencer
  localparam int unsigned NrVInsn = 8;
  // Words per lane in one vector register
  localparam int unsigned BeatsPerVreg = 4;
  // Largest supported lane count, sizes the vl field
  localparam int unsigned MaxLanes = 16;
  localparam int unsigned NrVRegs = 32;

  //////////////////////////////
  // Scalar types
  //////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [ElenBits-1:0] elen_t;
  // vl in bits, up to a full register at the largest lane count
  typedef logic [$clog2(MaxLanes*ElenBits*BeatsPerVreg+1)-1:0] vlen_t;
  // Lane register file word address, vd * BeatsPerVreg + beat
  typedef logic [$clog2(NrVRegs*BeatsPerVreg)-1:0] vaddr_t;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Instruction from the sequencer; vm set means unmasked
  typedef struct packed {
    vid_t  id;
    vlen_t vl;
    vreg_t vd;
    logic  vm;
  } pe_req_t;

  // One-hot completion strobe
  typedef struct packed {
    logic [NrVInsn-1:0] vinsn_done;
  } pe_resp_t;

  // One write toward a lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
  } lane_result_t;

endpackage

`default_nettype wire

//--- verilog/masku_insn_ctrl.sv
// Mask unit instruction control
// Holds the single in-flight instruction, counts issued and committed bits, raises done

`timescale 1ns/100ps
`default_nettype none

module masku_insn_ctrl import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Sequencer side
  input  pe_req_t  pe_req_i,
  input  logic     pe_req_valid_i,
  output logic     pe_req_ready_o,
  output pe_resp_t pe_resp_o,
  // Progress from the datapath
  input  logic     beat_fire_i,
  input  logic     word_commit_i,
  // Toward the merge ALU
  output pe_req_t  insn_issue_o,
  output logic     issue_valid_o,
  output vlen_t    issue_cnt_o
);

  // Bits covered by one beat across all lanes
  localparam vlen_t BeatStep = vlen_t'(NrLanes * ElenBits);

  //////////////////////////////
  // State
  //////////////////////////////

  logic     busy_q;
  pe_req_t  insn_q;
  vlen_t    issue_cnt_q, issue_cnt_d;
  vlen_t    commit_cnt_q, commit_cnt_d;
  logic     accept;
  logic     last_commit;
  pe_resp_t pe_resp_d;

  // Queue depth of one, so ready is just not busy
  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && !busy_q;

  assign insn_issue_o  = insn_q;
  assign issue_valid_o = busy_q && (issue_cnt_q != '0);
  assign issue_cnt_o   = issue_cnt_q;

  //////////////////////////////
  // Counters
  //////////////////////////////

  always_comb begin
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    last_commit  = 1'b0;
    pe_resp_d    = '0;

    // Remaining bits to issue, floored at zero
    if (beat_fire_i) begin
      issue_cnt_d = (issue_cnt_q > BeatStep) ? issue_cnt_q - BeatStep : '0;
    end

    // Remaining bits to commit
    if (word_commit_i) begin
      commit_cnt_d = (commit_cnt_q > BeatStep) ? commit_cnt_q - BeatStep : '0;
      // Last word left the queue in all lanes
      if (busy_q && (commit_cnt_d == '0)) begin
        last_commit                     = 1'b1;
        pe_resp_d.vinsn_done[insn_q.id] = 1'b1;
      end
    end

    // New instruction loads both counters with vl
    if (accept) begin
      issue_cnt_d  = pe_req_i.vl;
      commit_cnt_d = pe_req_i.vl;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      pe_resp_o    <= '0;
    end else begin
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      // Done pulse is registered, one cycle wide
      pe_resp_o    <= pe_resp_d;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (last_commit) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Instruction payload, only read while busy
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/masku_merge_alu.sv
// Mask unit merge ALU
// Gathers one beat from all lanes, builds the bit enable and merges a with b

`timescale 1ns/100ps
`default_nettype none

module masku_merge_alu import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  // Current instruction
  input  pe_req_t                    insn_issue_i,
  input  logic                       issue_valid_i,
  input  vlen_t                      issue_cnt_i,
  // Operand a, the lane result
  input  elen_t        [NrLanes-1:0] masku_operand_a_i,
  input  logic         [NrLanes-1:0] masku_operand_a_valid_i,
  output logic         [NrLanes-1:0] masku_operand_a_ready_o,
  // Operand b, old destination value
  input  elen_t        [NrLanes-1:0] masku_operand_b_i,
  input  logic         [NrLanes-1:0] masku_operand_b_valid_i,
  output logic         [NrLanes-1:0] masku_operand_b_ready_o,
  // Operand m, the mask register
  input  elen_t        [NrLanes-1:0] masku_operand_m_i,
  input  logic         [NrLanes-1:0] masku_operand_m_valid_i,
  output logic         [NrLanes-1:0] masku_operand_m_ready_o,
  // Result queue side
  input  logic                       queue_full_i,
  output logic                       beat_fire_o,
  output lane_result_t [NrLanes-1:0] push_o
);

  localparam int unsigned BeatBits  = NrLanes * ElenBits;
  // Lane counts are powers of two, so the beat index is a shift
  localparam int unsigned BeatShift = $clog2(BeatBits);

  logic                operands_valid;
  logic [BeatBits-1:0] a_flat;
  logic [BeatBits-1:0] b_flat;
  logic [BeatBits-1:0] m_flat;
  logic [BeatBits-1:0] bit_enable;
  logic [BeatBits-1:0] bit_enable_mask;
  logic [BeatBits-1:0] merged;
  vlen_t               issued_bits;
  vlen_t               beat_idx;
  vaddr_t              beat_addr;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // m only matters for a masked instruction
  assign operands_valid = (&masku_operand_a_valid_i) && (&masku_operand_b_valid_i) &&
                          (insn_issue_i.vm || (&masku_operand_m_valid_i));

  assign beat_fire_o = issue_valid_i && operands_valid && !queue_full_i;

  // Readies mirror the valids only in the firing cycle
  assign masku_operand_a_ready_o = beat_fire_o ? masku_operand_a_valid_i : '0;
  assign masku_operand_b_ready_o = beat_fire_o ? masku_operand_b_valid_i : '0;
  assign masku_operand_m_ready_o = (beat_fire_o && !insn_issue_i.vm) ?
                                   masku_operand_m_valid_i : '0;

  //////////////////////////////
  // Bit enable and merge
  //////////////////////////////

  // Lane-major layout, lane l holds bits [l*64 +: 64]
  assign a_flat = masku_operand_a_i;
  assign b_flat = masku_operand_b_i;
  assign m_flat = masku_operand_m_i;

  always_comb begin
    // Bits below the remaining count are still inside vl
    for (int i = 0; i < BeatBits; i++) begin
      bit_enable[i] = (vlen_t'(i) < issue_cnt_i);
    end
    // Masked instructions drop bits with a clear m bit
    bit_enable_mask = insn_issue_i.vm ? bit_enable : (bit_enable & m_flat);
    // Take a where enabled, keep b elsewhere
    merged = (a_flat & bit_enable_mask) | (b_flat & ~bit_enable_mask);
  end

  //////////////////////////////
  // Address
  //////////////////////////////

  // Bits already issued give the beat within the register
  assign issued_bits = insn_issue_i.vl - issue_cnt_i;
  assign beat_idx    = issued_bits >> BeatShift;
  assign beat_addr   = vaddr_t'(insn_issue_i.vd) * vaddr_t'(BeatsPerVreg) + vaddr_t'(beat_idx);

  // One queued write per lane
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      push_o[l].id    = insn_issue_i.id;
      push_o[l].addr  = beat_addr;
      push_o[l].wdata = merged[l*ElenBits +: ElenBits];
    end
  end

endmodule

`default_nettype wire

//--- verilog/masku_result_queue.sv
// Mask unit result queue
// Two entries, each written to all lanes by per-lane request and grant

`timescale 1ns/100ps
`default_nettype none

module masku_result_queue import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Push from the merge ALU
  input  logic                       push_valid_i,
  input  lane_result_t [NrLanes-1:0] push_i,
  output logic                       full_o,
  // Toward the lanes
  output logic         [NrLanes-1:0] result_req_o,
  output lane_result_t [NrLanes-1:0] result_o,
  input  logic         [NrLanes-1:0] result_gnt_i,
  // Entry granted by every lane
  output logic                       word_commit_o
);

  localparam int unsigned Depth    = 2;
  localparam int unsigned PtrWidth = $clog2(Depth);

  //////////////////////////////
  // Storage
  //////////////////////////////

  lane_result_t [Depth-1:0][NrLanes-1:0] queue_q;
  logic         [Depth-1:0][NrLanes-1:0] valid_q, valid_d;
  logic         [PtrWidth-1:0]           wr_ptr_q;
  logic         [PtrWidth-1:0]           rd_ptr_q;
  logic         [PtrWidth:0]             cnt_q, cnt_d;
  logic         [NrLanes-1:0]            head_left;
  logic                                  empty;

  assign full_o = (cnt_q == Depth[PtrWidth:0]);
  assign empty  = (cnt_q == '0);

  // Head entry drives all lanes
  assign result_req_o = valid_q[rd_ptr_q];
  assign result_o     = queue_q[rd_ptr_q];

  // Lanes of the head still waiting after this cycle's grants
  assign head_left = valid_q[rd_ptr_q] & ~result_gnt_i;

  // Pop once no lane of the head still requests
  assign word_commit_o = !empty && (head_left == '0);

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    valid_d = valid_q;
    cnt_d   = cnt_q;

    // Granted lanes drop their request
    valid_d[rd_ptr_q] = head_left;

    // New entry requests in every lane
    if (push_valid_i) begin
      valid_d[wr_ptr_q] = '1;
    end

    if (push_valid_i && !word_commit_o) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!push_valid_i && word_commit_o) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      cnt_q   <= cnt_d;
      // Depth is a power of two, pointers wrap on their own
      if (push_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (word_commit_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Payload, written only into a free slot so the head stays stable
  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      queue_q[wr_ptr_q] <= push_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/masku_top.sv
// Mask unit top level
// Instruction control, merge ALU and result queue of the mask-logical path

`timescale 1ns/100ps
`default_nettype none

module masku_top import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Sequencer
  input  pe_req_t                    pe_req_i,
  input  logic                       pe_req_valid_i,
  output logic                       pe_req_ready_o,
  output pe_resp_t                   pe_resp_o,
  // Operand channels from the lanes
  input  elen_t        [NrLanes-1:0] masku_operand_a_i,
  input  logic         [NrLanes-1:0] masku_operand_a_valid_i,
  output logic         [NrLanes-1:0] masku_operand_a_ready_o,
  input  elen_t        [NrLanes-1:0] masku_operand_b_i,
  input  logic         [NrLanes-1:0] masku_operand_b_valid_i,
  output logic         [NrLanes-1:0] masku_operand_b_ready_o,
  input  elen_t        [NrLanes-1:0] masku_operand_m_i,
  input  logic         [NrLanes-1:0] masku_operand_m_valid_i,
  output logic         [NrLanes-1:0] masku_operand_m_ready_o,
  // Result writes to the lanes
  output logic         [NrLanes-1:0] result_req_o,
  output lane_result_t [NrLanes-1:0] result_o,
  input  logic         [NrLanes-1:0] result_gnt_i
);

  // Stage interconnect
  pe_req_t                    insn_issue;
  logic                       issue_valid;
  vlen_t                      issue_cnt;
  logic                       beat_fire;
  logic                       word_commit;
  logic                       queue_full;
  lane_result_t [NrLanes-1:0] push;

  // Input side
  masku_insn_ctrl #(
    .NrLanes (NrLanes)
  ) i_insn_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .pe_resp_o      (pe_resp_o),
    .beat_fire_i    (beat_fire),
    .word_commit_i  (word_commit),
    .insn_issue_o   (insn_issue),
    .issue_valid_o  (issue_valid),
    .issue_cnt_o    (issue_cnt)
  );

  // Processing
  masku_merge_alu #(
    .NrLanes (NrLanes)
  ) i_merge_alu (
    .insn_issue_i            (insn_issue),
    .issue_valid_i           (issue_valid),
    .issue_cnt_i             (issue_cnt),
    .masku_operand_a_i       (masku_operand_a_i),
    .masku_operand_a_valid_i (masku_operand_a_valid_i),
    .masku_operand_a_ready_o (masku_operand_a_ready_o),
    .masku_operand_b_i       (masku_operand_b_i),
    .masku_operand_b_valid_i (masku_operand_b_valid_i),
    .masku_operand_b_ready_o (masku_operand_b_ready_o),
    .masku_operand_m_i       (masku_operand_m_i),
    .masku_operand_m_valid_i (masku_operand_m_valid_i),
    .masku_operand_m_ready_o (masku_operand_m_ready_o),
    .queue_full_i            (queue_full),
    .beat_fire_o             (beat_fire),
    .push_o                  (push)
  );

  // Output side
  masku_result_queue #(
    .NrLanes (NrLanes)
  ) i_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_valid_i  (beat_fire),
    .push_i        (push),
    .full_o        (queue_full),
    .result_req_o  (result_req_o),
    .result_o      (result_o),
    .result_gnt_i  (result_gnt_i),
    .word_commit_o (word_commit)
  );

endmodule

`default_nettype wire

//--- testbench/masku_chk.sv
// Mask unit protocol checks
// Handshake and timing rules on the top-level ports, bound into the DUT

`timescale 1ns/100ps
`default_nettype none

module masku_chk import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  pe_req_t                    pe_req_i,
  input  logic                       pe_req_valid_i,
  input  logic                       pe_req_ready_o,
  input  pe_resp_t                   pe_resp_o,
  input  logic         [NrLanes-1:0] result_req_o,
  input  lane_result_t [NrLanes-1:0] result_o,
  input  logic         [NrLanes-1:0] result_gnt_i
);

  // Failed assertions, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  //////////////////////////////
  // Result handshake
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    // Request holds with stable payload until granted
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] && $stable(result_o[l]))
      else begin
        $error("lane %0d dropped or changed its request before the grant", l);
        fail_cnt++;
      end
  end

  //////////////////////////////
  // Sequencer side
  //////////////////////////////

  // Done is a single-cycle one-hot pulse
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|pe_resp_o.vinsn_done) |-> $onehot(pe_resp_o.vinsn_done) ##1 !(|pe_resp_o.vinsn_done))
    else begin
      $error("done pulse is not one-hot or lasts more than one cycle");
      fail_cnt++;
    end

  // Accepting makes the unit busy
  busy_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && pe_req_ready_o |=> !pe_req_ready_o)
    else begin
      $error("ready stayed high after an instruction was accepted");
      fail_cnt++;
    end

  // Busy only ends with the done pulse
  ready_with_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(pe_req_ready_o) |-> (|pe_resp_o.vinsn_done))
    else begin
      $error("ready rose without a done pulse");
      fail_cnt++;
    end

  vl_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i |-> (pe_req_i.vl != '0))
    else begin
      $error("instruction offered with vl of zero");
      fail_cnt++;
    end

endmodule

bind masku_top masku_chk #(
  .NrLanes (NrLanes)
) i_masku_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .pe_req_i       (pe_req_i),
  .pe_req_valid_i (pe_req_valid_i),
  .pe_req_ready_o (pe_req_ready_o),
  .pe_resp_o      (pe_resp_o),
  .result_req_o   (result_req_o),
  .result_o       (result_o),
  .result_gnt_i   (result_gnt_i)
);

`default_nettype wire

//--- testbench/tb_masku.sv
// Mask unit testbench
// Lane and sequencer model, scoreboard by the beat rule, random grants

`timescale 1ns/100ps
`default_nettype none

module tb_masku import masku_pkg::*;;

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned BeatBits      = NrLanes * ElenBits;
  localparam int unsigned NumTests      = 10;
  localparam int unsigned TimeoutCycles = NumTests * 4 * BeatsPerVreg * 20;

  logic                       clk_i;
  logic                       rst_ni;
  pe_req_t                    pe_req_i;
  logic                       pe_req_valid_i;
  logic                       pe_req_ready_o;
  pe_resp_t                   pe_resp_o;
  elen_t        [NrLanes-1:0] masku_operand_a_i;
  elen_t        [NrLanes-1:0] masku_operand_b_i;
  elen_t        [NrLanes-1:0] masku_operand_m_i;
  logic         [NrLanes-1:0] masku_operand_a_valid_i;
  logic         [NrLanes-1:0] masku_operand_b_valid_i;
  logic         [NrLanes-1:0] masku_operand_m_valid_i;
  logic         [NrLanes-1:0] masku_operand_a_ready_o;
  logic         [NrLanes-1:0] masku_operand_b_ready_o;
  logic         [NrLanes-1:0] masku_operand_m_ready_o;
  logic         [NrLanes-1:0] result_req_o;
  lane_result_t [NrLanes-1:0] result_o;
  logic         [NrLanes-1:0] result_gnt_i;

  // Scoreboard state
  lane_result_t exp_q [NrLanes][$];
  string        test_name;
  int unsigned  checks;
  int unsigned  errors;
  int unsigned  done_events;
  int unsigned  beat_k;
  bit           running;
  bit           active;
  bit           done_due;
  bit           beat_fired;
  vid_t         cur_id;
  vlen_t        cur_vl;
  vreg_t        cur_vd;
  logic         cur_vm;

  masku_top #(
    .NrLanes (NrLanes)
  ) dut (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .pe_req_i                (pe_req_i),
    .pe_req_valid_i          (pe_req_valid_i),
    .pe_req_ready_o          (pe_req_ready_o),
    .pe_resp_o               (pe_resp_o),
    .masku_operand_a_i       (masku_operand_a_i),
    .masku_operand_a_valid_i (masku_operand_a_valid_i),
    .masku_operand_a_ready_o (masku_operand_a_ready_o),
    .masku_operand_b_i       (masku_operand_b_i),
    .masku_operand_b_valid_i (masku_operand_b_valid_i),
    .masku_operand_b_ready_o (masku_operand_b_ready_o),
    .masku_operand_m_i       (masku_operand_m_i),
    .masku_operand_m_valid_i (masku_operand_m_valid_i),
    .masku_operand_m_ready_o (masku_operand_m_ready_o),
    .result_req_o            (result_req_o),
    .result_o                (result_o),
    .result_gnt_i            (result_gnt_i)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic report_mismatch(string what, logic [127:0] want, logic [127:0] got);
    errors++;
    $display("Fail %s %s: expected %h, actual %h", test_name, what, want, got);
  endtask

  task automatic report_error(string what);
    errors++;
    $display("Error in %s: %s", test_name, what);
  endtask

  // Bit i of lane l in beat k takes a inside vl where the mask allows it
  function automatic elen_t expected_word(elen_t a, elen_t b, elen_t m, int unsigned k,
                                          int unsigned l, vlen_t vl, logic vm);
    elen_t       w;
    int unsigned idx;
    for (int i = 0; i < ElenBits; i++) begin
      idx  = k * BeatBits + l * ElenBits + i;
      w[i] = ((idx < vl) && (vm || m[i])) ? a[i] : b[i];
    end
    return w;
  endfunction

  // Entries not yet granted by the slowest lane
  function automatic int unsigned pending_words();
    int unsigned n;
    n = 0;
    for (int l = 0; l < NrLanes; l++) begin
      if (exp_q[l].size() > n) n = exp_q[l].size();
    end
    return n;
  endfunction

  task automatic refresh_operands();
    for (int l = 0; l < NrLanes; l++) begin
      masku_operand_a_i[l] = {$urandom, $urandom};
      masku_operand_b_i[l] = {$urandom, $urandom};
      masku_operand_m_i[l] = {$urandom, $urandom};
    end
  endtask

  // Looks at the handshakes that the next rising edge will take
  task automatic observe();
    lane_result_t       want;
    logic [NrVInsn-1:0] want_done;
    bit                 fire;
    want_done = done_due ? (NrVInsn'(1) << cur_id) : '0;
    checks++;
    assert (pe_resp_o.vinsn_done == want_done) else
      report_mismatch("done", want_done, pe_resp_o.vinsn_done);
    if (done_due) begin
      done_events++;
      checks++;
      assert (pe_req_ready_o) else report_error("ready did not rise with done");
    end
    done_due = 1'b0;
    // A full queue stalls the operands
    checks++;
    assert (!(pending_words() >= 2 && masku_operand_a_ready_o != '0)) else
      report_error("operand ready high while the result queue is full");
    for (int l = 0; l < NrLanes; l++) begin
      if (result_req_o[l] && result_gnt_i[l]) begin
        if (exp_q[l].size() == 0) begin
          report_error($sformatf("unexpected write in lane %0d", l));
        end else begin
          want = exp_q[l].pop_front();
          checks++;
          assert (result_o[l] == want) else
            report_mismatch($sformatf("lane %0d write", l), want, result_o[l]);
        end
      end
    end
    // Last word gone in all lanes, done follows next cycle
    if (active && (beat_k * BeatBits >= cur_vl) && (pending_words() == 0)) begin
      done_due = 1'b1;
      active   = 1'b0;
    end
    fire = (masku_operand_a_ready_o == '1);
    checks++;
    assert ((masku_operand_b_ready_o == masku_operand_a_ready_o) &&
            (masku_operand_m_ready_o == ((fire && !cur_vm) ? '1 : '0))) else
      report_error("operand readies disagree across channels");
    if (fire) begin
      for (int l = 0; l < NrLanes; l++) begin
        want.id    = cur_id;
        want.addr  = vaddr_t'(cur_vd * BeatsPerVreg + beat_k);
        want.wdata = expected_word(masku_operand_a_i[l], masku_operand_b_i[l],
                                   masku_operand_m_i[l], beat_k, l, cur_vl, cur_vm);
        exp_q[l].push_back(want);
      end
      beat_k++;
    end
    beat_fired = fire;
  endtask

  // Lane model, fresh operands after each beat and random grants
  always @(negedge clk_i) begin
    if (running) begin
      if (beat_fired) refresh_operands();
      result_gnt_i = NrLanes'($urandom);
      #2;
      observe();
    end
  end

  task automatic run_insn(string name, vid_t id, vlen_t vl, vreg_t vd, logic vm);
    int unsigned seen;
    @(negedge clk_i);
    test_name = name;
    cur_id    = id;
    cur_vl    = vl;
    cur_vd    = vd;
    cur_vm    = vm;
    beat_k    = 0;
    active    = 1'b1;
    seen      = done_events;
    checks++;
    assert (pe_req_ready_o) else report_error("unit busy when a new instruction is offered");
    pe_req_i       = '{id: id, vl: vl, vd: vd, vm: vm};
    pe_req_valid_i = 1'b1;
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
    while (done_events == seen) @(negedge clk_i);
    // Extra cycles catch a repeated done
    repeat (2) @(negedge clk_i);
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    void'($urandom(98));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    running        = 1'b0;
    active         = 1'b0;
    done_due       = 1'b0;
    beat_fired     = 1'b0;
    checks         = 0;
    errors         = 0;
    done_events    = 0;
    test_name      = "reset";
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    result_gnt_i   = '0;
    cur_vm         = 1'b1;
    // Lanes always have operands ready to hand over
    masku_operand_a_valid_i = '1;
    masku_operand_b_valid_i = '1;
    masku_operand_m_valid_i = '1;
    refresh_operands();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    #2;
    checks++;
    assert (pe_req_ready_o && (result_req_o == '0) && (pe_resp_o == '0)) else
      report_error("outputs not idle after reset");
    checks++;
    assert ((masku_operand_a_ready_o | masku_operand_b_ready_o |
             masku_operand_m_ready_o) == '0) else
      report_error("operand ready high after reset");
    running = 1'b1;
    run_insn("unmasked_tail", 3'd1, 13'd100, 5'd2, 1'b1);
    run_insn("masked", 3'd2, 13'd700, 5'd9, 1'b0);
    run_insn("multi_beat", 3'd5, 13'd1024, 5'd7, 1'b1);
    run_insn("masked_tail", 3'd6, 13'd333, 5'd31, 1'b0);
    for (int t = 0; t < NumTests - 4; t++) begin
      run_insn($sformatf("random_grant_%0d", t), vid_t'(t), vlen_t'(1 + $urandom % 1024),
               vreg_t'($urandom), logic'($urandom % 2));
    end
    test_name = "drain";
    for (int l = 0; l < NrLanes; l++) begin
      checks++;
      assert (exp_q[l].size() == 0) else
        report_error($sformatf("lane %0d never received %0d words", l, exp_q[l].size()));
    end
    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
             dut.i_masku_chk.fail_cnt);
    if ((errors == 0) && (dut.i_masku_chk.fail_cnt == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/masku_pkg.sv
verilog/masku_insn_ctrl.sv
verilog/masku_merge_alu.sv
verilog/masku_result_queue.sv
verilog/masku_top.sv
testbench/masku_chk.sv
testbench/tb_masku.sv

//--- Bender.yml
package:
  name: masku

sources:
  # Design, in compile order
  - files:
      - verilog/masku_pkg.sv
      - verilog/masku_insn_ctrl.sv
      - verilog/masku_merge_alu.sv
      - verilog/masku_result_queue.sv
      - verilog/masku_top.sv

  # Verification
  - target: test
    files:
      - testbench/masku_chk.sv
      - testbench/tb_masku.sv
